//--- Bender.yml
package:
  name: stream_monitor

sources:
  - logic/stream_monitor_pkg.sv
  - logic/stream_stat.sv
  - logic/frame_fifo.sv
  - logic/stat_regs.sv
  - logic/stream_monitor_top.sv
  - target: simulation
    files:
      - sim/tb_clock.sv
      - sim/stream_monitor_properties.sv
      - sim/stream_monitor_tb.sv

//--- compile.f
logic/stream_monitor_pkg.sv
logic/stream_stat.sv
logic/frame_fifo.sv
logic/stat_regs.sv
logic/stream_monitor_top.sv
sim/tb_clock.sv
sim/stream_monitor_properties.sv
sim/stream_monitor_tb.sv

//--- logic/frame_fifo.sv
`timescale 1ns/1ps

module frame_fifo #(
  parameter int keep_width = 8,   // byte lanes per beat.
  parameter int fifo_depth = 16   // beats of storage, a power of two.
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    drop_mode,  // discard on overflow instead of stalling.
  input  logic [8*keep_width-1:0] in_data,
  input  logic [keep_width-1:0]   in_keep,
  input  logic                    in_valid,
  input  logic                    in_last,
  input  logic                    in_bad,     // sampled on the last beat only.
  output logic                    in_ready,
  output logic [8*keep_width-1:0] out_data,
  output logic [keep_width-1:0]   out_keep,
  output logic                    out_valid,
  output logic                    out_last,
  input  logic                    out_ready,
  output logic                    overflow_drop,  // pulse after an overflowing frame ends.
  output logic                    bad_drop        // pulse after a bad frame ends.
);

  localparam int data_width = 8 * keep_width;       // payload bits per beat.
  localparam int addr_width = $clog2(fifo_depth);   // bits to index the storage.
  localparam int ptr_width = addr_width + 1;        // the extra bit tells full from empty.

  logic [data_width-1:0] mem_data [fifo_depth];  // beat payload storage.
  logic [keep_width-1:0] mem_keep [fifo_depth];  // keep travels with its beat.
  logic                  mem_last [fifo_depth];  // frame boundaries stay in the storage.

  logic [ptr_width-1:0] wr_ptr;      // next slot for an incoming beat.
  logic [ptr_width-1:0] commit_ptr;  // end of the last complete good frame.
  logic [ptr_width-1:0] rd_ptr;      // next slot for the output stage.
  logic [ptr_width-1:0] level;       // beats held, committed or not.

  logic dropping;  // the current input frame has overflowed and is being discarded.
  logic full;      // no slot is free for another beat.
  logic stuck;     // full with no committed beat, so the frame can never fit.
  logic accept;    // an input beat moves this cycle.
  logic overflow;  // the accepted beat has no room or belongs to a discarded frame.
  logic store;     // the accepted beat is written into the storage.
  logic load;      // the output stage takes the next committed beat.

  assign level = wr_ptr - rd_ptr;  // wraps cleanly because the depth is a power of two.
  assign full = (level == ptr_width'(fifo_depth));
  assign stuck = full && (commit_ptr == rd_ptr);  // an over-long frame fills everything.

  // in drop mode the input never waits, and a frame that can never fit is taken and
  // thrown away so that the buffer does not lock up without drop mode either.
  assign in_ready = drop_mode || dropping || stuck || !full;

  assign accept = in_valid && in_ready;
  assign overflow = accept && (dropping || full);
  assign store = accept && !overflow;

  // only committed frames are visible, and a new beat loads when the stage is free.
  assign load = (commit_ptr != rd_ptr) && (!out_valid || out_ready);

  always_ff @(posedge clk) begin
    if (store) begin
      mem_data[wr_ptr[addr_width-1:0]] <= in_data;  // a bad beat lands past commit_ptr.
      mem_keep[wr_ptr[addr_width-1:0]] <= in_keep;
      mem_last[wr_ptr[addr_width-1:0]] <= in_last;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      commit_ptr <= '0;
      dropping <= 1'b0;
      overflow_drop <= 1'b0;
      bad_drop <= 1'b0;
    end else begin
      overflow_drop <= 1'b0;  // both drop outputs are single-cycle pulses.
      bad_drop <= 1'b0;
      if (overflow) begin
        wr_ptr <= commit_ptr;        // free the partial frame at once.
        dropping <= !in_last;        // the rest of the frame goes too.
        overflow_drop <= in_last;    // counted once the frame has ended.
      end else if (store) begin
        if (in_last && in_bad) begin
          wr_ptr <= commit_ptr;      // rewind over the whole bad frame.
          bad_drop <= 1'b1;
        end else if (in_last) begin
          wr_ptr <= wr_ptr + 1'b1;
          commit_ptr <= wr_ptr + 1'b1;  // the frame becomes visible to the output.
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr <= '0;
      out_valid <= 1'b0;
    end else if (load) begin
      rd_ptr <= rd_ptr + 1'b1;  // the slot is free once its beat sits in the stage.
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;  // the held beat has gone and nothing follows yet.
    end
  end

  // the output stage only changes on a load, so a refused beat holds steady.
  always_ff @(posedge clk) begin
    if (load) begin
      out_data <= mem_data[rd_ptr[addr_width-1:0]];
      out_keep <= mem_keep[rd_ptr[addr_width-1:0]];
      out_last <= mem_last[rd_ptr[addr_width-1:0]];
    end
  end

endmodule

//--- logic/stat_regs.sv
`timescale 1ns/1ps

module stat_regs (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          wr_en,
  input  stream_monitor_pkg::reg_addr_t wr_addr,
  input  stream_monitor_pkg::count_t    wr_data,
  input  logic                          rd_en,
  input  stream_monitor_pkg::reg_addr_t rd_addr,
  output stream_monitor_pkg::count_t    rd_data,     // valid together with rd_valid.
  output logic                          rd_valid,    // one cycle after rd_en.
  input  stream_monitor_pkg::count_t    in_bytes,
  input  stream_monitor_pkg::count_t    in_frames,
  input  stream_monitor_pkg::count_t    in_drops,
  input  stream_monitor_pkg::count_t    in_stalls,
  input  stream_monitor_pkg::count_t    out_bytes,
  input  stream_monitor_pkg::count_t    out_frames,
  input  stream_monitor_pkg::count_t    out_drops,
  input  stream_monitor_pkg::count_t    out_stalls,
  output logic                          stat_clear,  // one-cycle pulse to both monitors.
  output logic                          drop_mode    // level to the frame buffer.
);

  stream_monitor_pkg::count_t rd_mux;  // read value selected by rd_addr.

  always_comb begin
    case (rd_addr)
      stream_monitor_pkg::addr_in_bytes:   rd_mux = in_bytes;
      stream_monitor_pkg::addr_in_frames:  rd_mux = in_frames;
      stream_monitor_pkg::addr_in_drops:   rd_mux = in_drops;
      stream_monitor_pkg::addr_in_stalls:  rd_mux = in_stalls;
      stream_monitor_pkg::addr_out_bytes:  rd_mux = out_bytes;
      stream_monitor_pkg::addr_out_frames: rd_mux = out_frames;
      stream_monitor_pkg::addr_out_drops:  rd_mux = out_drops;
      stream_monitor_pkg::addr_out_stalls: rd_mux = out_stalls;
      stream_monitor_pkg::addr_ctrl:       rd_mux = stream_monitor_pkg::count_t'(drop_mode);
      default:                             rd_mux = '0;  // the clear address reads zero too.
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_mode <= 1'b0;   // stall on a full buffer after reset.
      stat_clear <= 1'b0;
    end else begin
      stat_clear <= wr_en && (wr_addr == stream_monitor_pkg::addr_clear);  // data is ignored.
      if (wr_en && (wr_addr == stream_monitor_pkg::addr_ctrl)) begin
        drop_mode <= wr_data[0];  // the upper control bits are reserved.
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;  // every read answers in exactly one cycle.
    end
  end

  // the read data register only moves on a read, so it holds between strobes.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= rd_mux;
    end
  end

endmodule

//--- logic/stream_monitor_pkg.sv
package stream_monitor_pkg;

  // every statistics counter and the register read data share this width.
  parameter int count_width = 32;

  // one counter value as seen by the statistics blocks and the register port.
  typedef logic [count_width-1:0] count_t;

  // the register map is small, so four address bits cover it with room to spare.
  typedef logic [3:0] reg_addr_t;

  // ingress side counters, watched before the frame buffer.
  parameter reg_addr_t addr_in_bytes = 4'd0;   // bytes accepted at the input.
  parameter reg_addr_t addr_in_frames = 4'd1;  // last beats accepted at the input.
  parameter reg_addr_t addr_in_drops = 4'd2;   // frames discarded on overflow.
  parameter reg_addr_t addr_in_stalls = 4'd3;  // cycles the input waited on in_ready.

  // egress side counters, watched after the frame buffer.
  parameter reg_addr_t addr_out_bytes = 4'd4;   // bytes sent at the output.
  parameter reg_addr_t addr_out_frames = 4'd5;  // frames sent at the output.
  parameter reg_addr_t addr_out_drops = 4'd6;   // frames discarded as bad.
  parameter reg_addr_t addr_out_stalls = 4'd7;  // cycles the output waited on out_ready.

  // control register, bit 0 selects drop mode on overflow.
  parameter reg_addr_t addr_ctrl = 4'd8;

  // any write to this address clears every counter on both sides.
  parameter reg_addr_t addr_clear = 4'd9;

  // addresses 10 to 15 are unused and read back as zero.

endpackage

//--- logic/stream_monitor_top.sv
`timescale 1ns/1ps

module stream_monitor_top #(
  parameter int keep_width = 8,   // byte lanes on both streams.
  parameter int fifo_depth = 16   // beats held by the frame buffer.
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [8*keep_width-1:0]       in_data,
  input  logic [keep_width-1:0]         in_keep,
  input  logic                          in_valid,
  output logic                          in_ready,
  input  logic                          in_last,
  input  logic                          in_bad,
  output logic [8*keep_width-1:0]       out_data,
  output logic [keep_width-1:0]         out_keep,
  output logic                          out_valid,
  input  logic                          out_ready,
  output logic                          out_last,
  input  logic                          wr_en,
  input  stream_monitor_pkg::reg_addr_t wr_addr,
  input  stream_monitor_pkg::count_t    wr_data,
  input  logic                          rd_en,
  input  stream_monitor_pkg::reg_addr_t rd_addr,
  output stream_monitor_pkg::count_t    rd_data,
  output logic                          rd_valid
);

  logic overflow_drop;  // ingress discard pulse from the buffer.
  logic bad_drop;       // egress discard pulse from the buffer.
  logic stat_clear;     // clears both monitors together.
  logic drop_mode;      // overflow policy for the buffer.

  stream_monitor_pkg::count_t in_bytes;
  stream_monitor_pkg::count_t in_frames;
  stream_monitor_pkg::count_t in_drops;
  stream_monitor_pkg::count_t in_stalls;
  stream_monitor_pkg::count_t out_bytes;
  stream_monitor_pkg::count_t out_frames;
  stream_monitor_pkg::count_t out_drops;
  stream_monitor_pkg::count_t out_stalls;

  frame_fifo #(
    .keep_width(keep_width),
    .fifo_depth(fifo_depth)
  ) frame_fifo_i (
    .clk(clk), .rst(rst), .drop_mode(drop_mode),
    .in_data(in_data), .in_keep(in_keep), .in_valid(in_valid),
    .in_last(in_last), .in_bad(in_bad), .in_ready(in_ready),
    .out_data(out_data), .out_keep(out_keep), .out_valid(out_valid),
    .out_last(out_last), .out_ready(out_ready),
    .overflow_drop(overflow_drop), .bad_drop(bad_drop)
  );

  // the ingress monitor sees every accepted beat, discarded or not.
  stream_stat #(.keep_width(keep_width)) ingress_stat (
    .clk(clk), .rst(rst), .clear(stat_clear),
    .mon_keep(in_keep), .mon_valid(in_valid), .mon_ready(in_ready),
    .mon_last(in_last), .mon_drop(overflow_drop),
    .byte_count(in_bytes), .frame_count(in_frames),
    .drop_count(in_drops), .stall_count(in_stalls)
  );

  // the egress monitor sees only good frames leaving the buffer.
  stream_stat #(.keep_width(keep_width)) egress_stat (
    .clk(clk), .rst(rst), .clear(stat_clear),
    .mon_keep(out_keep), .mon_valid(out_valid), .mon_ready(out_ready),
    .mon_last(out_last), .mon_drop(bad_drop),
    .byte_count(out_bytes), .frame_count(out_frames),
    .drop_count(out_drops), .stall_count(out_stalls)
  );

  stat_regs stat_regs_i (
    .clk(clk), .rst(rst),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data), .rd_valid(rd_valid),
    .in_bytes(in_bytes), .in_frames(in_frames),
    .in_drops(in_drops), .in_stalls(in_stalls),
    .out_bytes(out_bytes), .out_frames(out_frames),
    .out_drops(out_drops), .out_stalls(out_stalls),
    .stat_clear(stat_clear), .drop_mode(drop_mode)
  );

endmodule

//--- logic/stream_stat.sv
`timescale 1ns/1ps

module stream_stat #(
  parameter int keep_width = 8  // byte lanes on the watched stream.
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       clear,       // one-cycle pulse from the register block.
  input  logic [keep_width-1:0]      mon_keep,    // byte keep of the watched beat.
  input  logic                       mon_valid,
  input  logic                       mon_ready,
  input  logic                       mon_last,
  input  logic                       mon_drop,    // one-cycle pulse per discarded frame.
  output stream_monitor_pkg::count_t byte_count,
  output stream_monitor_pkg::count_t frame_count,
  output stream_monitor_pkg::count_t drop_count,
  output stream_monitor_pkg::count_t stall_count
);

  logic                       xfer;        // a beat moves in this cycle.
  logic                       stall;       // the source holds a beat the sink refuses.
  stream_monitor_pkg::count_t beat_bytes;  // byte count of the current beat.

  // returns the run of ones from bit 0, or zero when keep has a hole in it.
  function automatic stream_monitor_pkg::count_t keep_len(
    input logic [keep_width-1:0] keep
  );
    stream_monitor_pkg::count_t len;
    len = '0;
    for (int i = 0; i <= keep_width; i++) begin
      if (keep == ({keep_width{1'b1}} >> (keep_width - i))) begin
        len = stream_monitor_pkg::count_t'(i);  // only one mask can match.
      end
    end
    return len;
  endfunction

  assign xfer = mon_valid && mon_ready;    // the usual stream handshake.
  assign stall = mon_valid && !mon_ready;  // back-pressure seen by the source.
  assign beat_bytes = keep_len(mon_keep);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      byte_count <= '0;   // a clear wins over any event in the same cycle.
      frame_count <= '0;
      drop_count <= '0;
      stall_count <= '0;
    end else begin
      if (xfer) begin
        byte_count <= byte_count + beat_bytes;  // a malformed keep adds nothing.
      end
      if (xfer && mon_last) begin
        frame_count <= frame_count + 1'b1;  // frames end on the last beat.
      end
      if (stall) begin
        stall_count <= stall_count + 1'b1;
      end
      if (mon_drop) begin
        drop_count <= drop_count + 1'b1;
      end
    end
  end

endmodule

//--- sim/stream_monitor_properties.sv
`timescale 1ns/1ps

module stream_monitor_properties #(
  parameter int keep_width = 8  // byte lanes on the output stream.
) (
  input logic                    clk,
  input logic                    rst,
  input logic                    rd_en,
  input logic                    rd_valid,
  input logic                    out_valid,
  input logic                    out_ready,
  input logic [8*keep_width-1:0] out_data,
  input logic                    in_ready,
  input logic                    drop_mode   // internal level from the register block.
);

  int error_count = 0;  // failed assertions so far, watched by the testbench.

  // every register read answers in the very next cycle.
  read_latency: assert property (@(posedge clk) disable iff (rst)
    rd_valid == $past(rd_en))
    else begin
      $error("rd_valid did not follow rd_en by one cycle");
      error_count++;
    end

  // a refused output beat stays put until the sink takes it.
  hold_beat: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      $error("output beat changed while out_ready was low");
      error_count++;
    end

  // drop mode never back-pressures the source.
  no_stall_in_drop: assert property (@(posedge clk) disable iff (rst)
    drop_mode |-> in_ready)
    else begin
      $error("in_ready fell while drop mode was set");
      error_count++;
    end

endmodule

bind stream_monitor_top stream_monitor_properties #(.keep_width(keep_width)) props_i (
  .clk(clk), .rst(rst), .rd_en(rd_en), .rd_valid(rd_valid),
  .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
  .in_ready(in_ready), .drop_mode(drop_mode)
);

//--- sim/stream_monitor_tb.sv
`timescale 1ns/1ps

module stream_monitor_tb;

  localparam int keep_width = 8;
  localparam int fifo_depth = 16;
  localparam int data_width = 8 * keep_width;
  localparam int beat_width = data_width + keep_width + 1;  // data, keep and last packed.

  logic                          clk;
  logic                          rst;
  logic [data_width-1:0]         in_data;
  logic [keep_width-1:0]         in_keep;
  logic                          in_valid;
  logic                          in_ready;
  logic                          in_last;
  logic                          in_bad;
  logic [data_width-1:0]         out_data;
  logic [keep_width-1:0]         out_keep;
  logic                          out_valid;
  logic                          out_ready;
  logic                          out_last;
  logic                          wr_en;
  stream_monitor_pkg::reg_addr_t wr_addr;
  stream_monitor_pkg::count_t    wr_data;
  logic                          rd_en;
  stream_monitor_pkg::reg_addr_t rd_addr;
  stream_monitor_pkg::count_t    rd_data;
  logic                          rd_valid;

  stream_monitor_pkg::count_t exp_count [8];  // expected counters, indexed by address.
  logic [beat_width-1:0] exp_q [$];  // beats that should leave the buffer, in order.
  logic [beat_width-1:0] got_q [$];  // beats taken at the output.
  logic [31:0] lfsr_state;   // source of payload, keep and frame lengths.
  logic [31:0] ready_state;  // source of the out_ready pattern.
  logic [1:0]  ready_mode;   // 0 holds out_ready low, 1 holds it high, 2 is random.
  logic        drop_on;      // drop mode as last written.

  tb_clock clock_i (.clk(clk), .rst(rst));

  stream_monitor_top #(
    .keep_width(keep_width),
    .fifo_depth(fifo_depth)
  ) stream_monitor_top_i (.*);

  // galois form of x^32 + x^22 + x^2 + x + 1, shifting right.
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
  endfunction

  // a run of ones from bit 0 counts, anything with a hole in it counts nothing.
  function automatic int contig_bytes(input logic [keep_width-1:0] keep);
    int n;
    n = 0;
    while (n < keep_width && keep[n]) n++;
    if ((keep >> n) != 0) n = 0;  // a set bit above the run makes the keep malformed.
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [63:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val = {val[62:0], lfsr_state[0]};   // one step per bit.
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic stop_run();
    $display("Some tests failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic check_count(input string name, input stream_monitor_pkg::count_t got,
                             input stream_monitor_pkg::count_t exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERROR %s: got %h expected %h", name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_beat(input logic [beat_width-1:0] got, input logic [beat_width-1:0] exp);
    if (got[beat_width-1 -: data_width] !== exp[beat_width-1 -: data_width]) begin
      $display("ERROR out_data: got %h expected %h", got[beat_width-1 -: data_width],
               exp[beat_width-1 -: data_width]);
      stop_run();
    end
    if (got[keep_width:1] !== exp[keep_width:1]) begin
      $display("ERROR out_keep: got %h expected %h", got[keep_width:1], exp[keep_width:1]);
      stop_run();
    end
    check_flag("out_last", got[0], exp[0]);
  endtask

  // a failed bound assertion ends the run at the next edge.
  always @(posedge clk) begin
    if (stream_monitor_top_i.props_i.error_count != 0) begin
      $display("a concurrent assertion on the DUT failed");
      stop_run();
    end
  end

  // the sink records every output beat and every refused output cycle.
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) got_q.push_back({out_data, out_keep, out_last});
    if (!rst && out_valid && !out_ready) exp_count[stream_monitor_pkg::addr_out_stalls]++;
  end

  always @(posedge clk) begin
    if (ready_mode == 2'd2) begin
      out_ready <= ready_state[0];
      ready_state = lfsr_next(ready_state);
    end else begin
      out_ready <= ready_mode[0];
    end
  end

  task automatic write_reg(input stream_monitor_pkg::reg_addr_t addr,
                           input stream_monitor_pkg::count_t data);
    wr_en <= 1'b1;
    wr_addr <= addr;
    wr_data <= data;
    @(posedge clk);
    wr_en <= 1'b0;  // single-cycle write strobe.
  endtask

  task automatic read_reg(input stream_monitor_pkg::reg_addr_t addr,
                          output stream_monitor_pkg::count_t val);
    int waited;
    rd_en <= 1'b1;
    rd_addr <= addr;
    @(posedge clk);
    rd_en <= 1'b0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > 8) begin
        $display("register read at address %0d never returned rd_valid", addr);
        stop_run();
      end
    end while (!rd_valid);
    val = rd_data;
  endtask

  task automatic clear_counters();
    write_reg(stream_monitor_pkg::addr_clear, '0);
    @(posedge clk);  // the clear pulse wipes every event up to this edge.
    @(negedge clk);
    foreach (exp_count[i]) exp_count[i] = '0;  // events from the next edge on count again.
    @(posedge clk);
  endtask

  task automatic verify_counters();
    stream_monitor_pkg::count_t val;
    for (int a = 0; a < 8; a++) begin
      read_reg(stream_monitor_pkg::reg_addr_t'(a), val);
      check_count($sformatf("rd_data at address %0d", a), val, exp_count[a]);
    end
  endtask

  task automatic send_beat(input logic [data_width-1:0] data, input logic [keep_width-1:0] keep,
                           input logic last, input logic bad);
    int waited;
    in_data <= data;
    in_keep <= keep;
    in_last <= last;
    in_bad <= bad;
    in_valid <= 1'b1;
    waited = 0;
    do begin
      @(posedge clk);
      if (drop_on) check_flag("in_ready", in_ready, 1'b1);
      if (!in_ready) begin
        exp_count[stream_monitor_pkg::addr_in_stalls]++;  // a stall seen at the port.
        waited++;
        if (waited > 1000) begin
          $display("input beat was never accepted");
          stop_run();
        end
      end
    end while (!in_ready);
  endtask

  // random payload, full keep except a random keep on the last beat.
  task automatic send_frame(input int len, input logic bad, input logic leaves);
    logic [63:0] data;
    logic [63:0] bits;
    logic [keep_width-1:0] keep;
    logic last;
    for (int b = 0; b < len; b++) begin
      last = (b == len - 1);
      take_bits(data_width, data);
      keep = '1;
      if (last) begin
        take_bits(keep_width, bits);
        keep = bits[keep_width-1:0];
      end
      send_beat(data, keep, last, bad && last);
      exp_count[stream_monitor_pkg::addr_in_bytes] += contig_bytes(keep);
      if (leaves) begin
        exp_q.push_back({data, keep, last});
        exp_count[stream_monitor_pkg::addr_out_bytes] += contig_bytes(keep);
      end
    end
    exp_count[stream_monitor_pkg::addr_in_frames]++;
    if (leaves) exp_count[stream_monitor_pkg::addr_out_frames]++;
    if (bad) exp_count[stream_monitor_pkg::addr_out_drops]++;
  endtask

  task automatic drain_and_compare();
    int waited;
    logic [beat_width-1:0] exp_beat;
    waited = 0;
    do begin
      @(negedge clk);  // queue sizes and out_valid are settled here.
      waited++;
      if (waited > 2000) begin
        $display("output did not deliver the expected %0d beats", exp_q.size());
        stop_run();
      end
    end while (got_q.size() != exp_q.size() || out_valid);
    @(posedge clk);
    while (exp_q.size() > 0) begin
      exp_beat = exp_q.pop_front();
      check_beat(got_q.pop_front(), exp_beat);
    end
  endtask

  task automatic pass_through_frames();
    logic [63:0] r;
    for (int f = 0; f < 5; f++) begin
      take_bits(4, r);
      send_frame(int'(r[3:0]) + 1, 1'b0, 1'b1);  // one to fifo_depth beats.
    end
    in_valid <= 1'b0;
    drain_and_compare();
    verify_counters();
  endtask

  task automatic discard_bad_frame();
    logic [63:0] r;
    clear_counters();
    for (int f = 0; f < 3; f++) begin
      take_bits(3, r);
      send_frame(int'(r[2:0]) + 1, f == 1, f != 1);  // the middle frame is bad.
    end
    in_valid <= 1'b0;
    drain_and_compare();
    verify_counters();
  endtask

  task automatic overflow_in_drop_mode();
    logic [63:0] r;
    int occupied;
    int len;
    logic fits;
    write_reg(stream_monitor_pkg::addr_ctrl, 1);
    drop_on = 1'b1;
    ready_mode <= 2'd0;
    clear_counters();
    occupied = 0;
    for (int f = 0; f < 6; f++) begin
      take_bits(3, r);
      len = int'(r[2:0]) + 2;
      // the output register holds one more beat once a frame has been committed.
      fits = (occupied + len) <= (fifo_depth + ((occupied > 0) ? 1 : 0));
      if (fits) occupied += len;
      else exp_count[stream_monitor_pkg::addr_in_drops]++;
      send_frame(len, 1'b0, fits);
    end
    in_valid <= 1'b0;
    ready_mode <= 2'd1;
    drain_and_compare();
    verify_counters();
  endtask

  task automatic stall_under_back_pressure();
    write_reg(stream_monitor_pkg::addr_ctrl, 0);
    drop_on = 1'b0;
    clear_counters();
    ready_mode <= 2'd2;
    for (int f = 0; f < 6; f++) send_frame(8, 1'b0, 1'b1);  // back to back to fill the buffer.
    in_valid <= 1'b0;
    drain_and_compare();
    ready_mode <= 2'd1;
    verify_counters();
  endtask

  task automatic clear_and_read_map();
    stream_monitor_pkg::count_t val;
    write_reg(stream_monitor_pkg::addr_ctrl, 1);
    drop_on = 1'b1;
    clear_counters();
    verify_counters();  // every counter reads zero after the clear.
    read_reg(stream_monitor_pkg::addr_ctrl, val);
    check_count("rd_data at addr_ctrl", val, 1);
    read_reg(4'd12, val);
    check_count("rd_data at unused address 12", val, 0);
  endtask

  initial begin
    int waited;
    in_data = '0;
    in_keep = '0;
    in_valid = 1'b0;
    in_last = 1'b0;
    in_bad = 1'b0;
    out_ready = 1'b1;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    rd_en = 1'b0;
    rd_addr = '0;
    lfsr_state = 32'd81154;
    ready_state = 32'd81154;
    ready_mode = 2'd1;
    drop_on = 1'b0;
    foreach (exp_count[i]) exp_count[i] = '0;
    waited = 0;
    do begin
      @(posedge clk);
      waited++;
      if (waited > 20) begin
        $display("reset was never released");
        stop_run();
      end
    end while (rst);
    check_flag("in_ready", in_ready, 1'b1);
    check_flag("out_valid", out_valid, 1'b0);
    check_flag("rd_valid", rd_valid, 1'b0);
    pass_through_frames();
    discard_bad_frame();
    overflow_in_drop_mode();
    stall_under_back_pressure();
    clear_and_read_map();
    if (stream_monitor_top_i.props_i.error_count == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      $display("a concurrent assertion on the DUT failed");
      stop_run();
    end
  end

endmodule

//--- sim/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // half of the 4 ns period.
  end

  initial begin
    rst = 1'b1;                 // the design starts in reset.
    repeat (3) @(posedge clk);  // three full cycles with rst high.
    rst <= 1'b0;                // released just after an edge like any other input.
  end

endmodule
